// File: Makefile
VERILATOR ?= verilator
TOP       := proc_core_tb
FILELIST  := proc_core.f
VFLAGS    := --timing --assert
BUILD_DIR := obj_dir
PASS_MSG  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(shell grep -v '^+' $(FILELIST)) hw/proc_defs.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/proc_core.sv
// Single-cycle core, one instruction per valid strobe; the caller must present the word at pc
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_core import proc_pkg::*; (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic                   instr_valid,
        input  logic [31:0]            instr,
        output logic [`PROC_XLEN-1:0]  pc,
        output logic                   commit_valid,
        output logic [`PROC_XLEN-1:0]  commit_pc,
        output logic                   commit_wb_en,
        output logic [`PROC_REG_W-1:0] commit_rd,
        output logic [`PROC_XLEN-1:0]  commit_wb_data
);

        instr_u                instr_w;
        alu_fn_e               alu_fn;
        logic                  op0_sel;
        logic [1:0]            op1_sel;
        logic                  imm_u_sel;
        logic                  wb_sel;
        logic                  wb_en;
        logic [1:0]            pc_sel;
        logic                  ops_eq;
        logic                  ops_lt;
        logic                  ops_ltu;
        logic [`PROC_XLEN-1:0] imm_i;
        logic [`PROC_XLEN-1:0] imm_b;
        logic [`PROC_XLEN-1:0] imm_u;
        logic [`PROC_XLEN-1:0] imm_j;
        logic [`PROC_XLEN-1:0] rs1_data;
        logic [`PROC_XLEN-1:0] rs2_data;
        logic [`PROC_XLEN-1:0] op0;
        logic [`PROC_XLEN-1:0] op1;
        logic [`PROC_XLEN-1:0] alu_out;
        logic [`PROC_XLEN-1:0] pc_plus4;
        logic [`PROC_XLEN-1:0] target;
        logic [`PROC_XLEN-1:0] pc_next;
        logic [`PROC_XLEN-1:0] wb_data;
        logic                  rf_wen;

        assign instr_w = instr_u'(instr);

        proc_ctrl ctrl0 (
                .instr     (instr_w),
                .ops_eq    (ops_eq),
                .ops_lt    (ops_lt),
                .ops_ltu   (ops_ltu),
                .alu_fn    (alu_fn),
                .op0_sel   (op0_sel),
                .op1_sel   (op1_sel),
                .imm_u_sel (imm_u_sel),
                .wb_sel    (wb_sel),
                .wb_en     (wb_en),
                .pc_sel    (pc_sel)
        );

        proc_imm_gen imm0 (
                .instr (instr_w),
                .imm_i (imm_i),
                .imm_b (imm_b),
                .imm_u (imm_u),
                .imm_j (imm_j)
        );

        assign rf_wen = instr_valid && wb_en;              // x0 filtered inside the regfile

        proc_regfile rf0 (
                .clk    (clk),
                .rst_n  (rst_n),
                .raddr0 (instr_w.r.rs1),
                .raddr1 (instr_w.r.rs2),
                .rdata0 (rs1_data),
                .rdata1 (rs2_data),
                .wen    (rf_wen),
                .waddr  (instr_w.r.rd),
                .wdata  (wb_data)
        );

        assign op0 = op0_sel ? pc : rs1_data;

        always_comb begin
                case (op1_sel)
                        2'd1:    op1 = imm_i;
                        2'd2:    op1 = imm_u;
                        default: op1 = rs2_data;
                endcase
        end

        proc_dpath_alu alu0 (
                .in0     (op0),
                .in1     (op1),
                .fn      (alu_fn),
                .out     (alu_out),
                .ops_eq  (ops_eq),
                .ops_lt  (ops_lt),
                .ops_ltu (ops_ltu)
        );

        assign pc_plus4 = pc + `PROC_XLEN'd4;
        assign target   = pc + (imm_u_sel ? imm_j : imm_b);     // Branch and JAL target
        assign wb_data  = wb_sel ? pc_plus4 : alu_out;

        always_comb begin
                case (pc_sel)
                        2'd1:    pc_next = target;
                        2'd2:    pc_next = alu_out;        // JALR
                        default: pc_next = pc_plus4;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        pc           <= `PROC_RESET_PC;
                        commit_valid <= 1'b0;
                        commit_wb_en <= 1'b0;
                end else begin
                        commit_valid <= instr_valid;       // One-cycle pulse per retire
                        if (instr_valid) begin
                                pc           <= pc_next;
                                commit_wb_en <= wb_en;
                        end
                end
        end

        // Commit payload, qualified by commit_valid
        always_ff @(posedge clk) begin
                if (instr_valid) begin
                        commit_pc      <= pc;
                        commit_rd      <= instr_w.r.rd;
                        commit_wb_data <= wb_data;
                end
        end

endmodule

// File: hw/proc_ctrl.sv
// Combinational decode; unsupported opcodes retire as no-ops and funct7 is checked only at bit 5
`timescale 1ns/1ps

module proc_ctrl import proc_pkg::*; (
        input  instr_u      instr,
        input  logic        ops_eq,
        input  logic        ops_lt,
        input  logic        ops_ltu,
        output alu_fn_e     alu_fn,
        output logic        op0_sel,                       // 0 rs1, 1 pc
        output logic [1:0]  op1_sel,                       // 0 rs2, 1 imm_i, 2 imm_u
        output logic        imm_u_sel,                     // Target adder takes the J immediate
        output logic        wb_sel,                        // 0 alu, 1 pc+4
        output logic        wb_en,
        output logic [1:0]  pc_sel                         // 0 pc+4, 1 target adder, 2 alu
);

        logic [2:0] funct3;
        logic       alt;                                   // funct7 bit 5, picks SUB or SRA
        alu_fn_e    arith_fn;
        logic       br_taken;

        assign funct3 = instr.r.funct3;
        assign alt    = instr.r.funct7[5];

        // Shared by OP and OP_IMM, the SUB case is masked for immediates below
        always_comb begin
                case (funct3)
                        3'b000:  arith_fn = alt ? ALU_SUB : ALU_ADD;
                        3'b001:  arith_fn = ALU_SLL;
                        3'b010:  arith_fn = ALU_SLT;
                        3'b011:  arith_fn = ALU_SLTU;
                        3'b100:  arith_fn = ALU_XOR;
                        3'b101:  arith_fn = alt ? ALU_SRA : ALU_SRL;
                        3'b110:  arith_fn = ALU_OR;
                        default: arith_fn = ALU_AND;
                endcase
        end

        always_comb begin
                case (funct3)
                        3'b000:  br_taken = ops_eq;        // BEQ
                        3'b001:  br_taken = !ops_eq;       // BNE
                        3'b100:  br_taken = ops_lt;        // BLT
                        3'b101:  br_taken = !ops_lt;       // BGE
                        3'b110:  br_taken = ops_ltu;       // BLTU
                        3'b111:  br_taken = !ops_ltu;      // BGEU
                        default: br_taken = 1'b0;          // Reserved encodings fall through
                endcase
        end

        always_comb begin
                alu_fn    = ALU_ADD;
                op0_sel   = 1'b0;
                op1_sel   = 2'd0;
                imm_u_sel = 1'b0;
                wb_sel    = 1'b0;
                wb_en     = 1'b0;
                pc_sel    = 2'd0;

                case (instr.r.opcode)
                        OPC_OP: begin
                                alu_fn = arith_fn;
                                wb_en  = 1'b1;
                        end
                        OPC_OP_IMM: begin
                                // No SUBI, bit 30 is immediate data
                                alu_fn  = (funct3 == 3'b000) ? ALU_ADD : arith_fn;
                                op1_sel = 2'd1;
                                wb_en   = 1'b1;
                        end
                        OPC_LUI: begin
                                alu_fn  = ALU_CP_OP1;
                                op1_sel = 2'd2;
                                wb_en   = 1'b1;
                        end
                        OPC_AUIPC: begin
                                op0_sel = 1'b1;
                                op1_sel = 2'd2;
                                wb_en   = 1'b1;
                        end
                        OPC_JAL: begin
                                imm_u_sel = 1'b1;
                                wb_sel    = 1'b1;
                                wb_en     = 1'b1;
                                pc_sel    = 2'd1;
                        end
                        OPC_JALR: begin
                                alu_fn  = ALU_PC_ADD;      // Target rs1+imm, bit 0 cleared
                                op1_sel = 2'd1;
                                wb_sel  = 1'b1;
                                wb_en   = 1'b1;
                                pc_sel  = 2'd2;
                        end
                        OPC_BRANCH: begin
                                pc_sel = br_taken ? 2'd1 : 2'd0;
                        end
                        default: begin
                                // Retire as a no-op
                        end
                endcase
        end

endmodule

// File: hw/proc_defs.svh
// Widths are fixed for RV32I; changing PROC_XLEN alone does not resize the instruction formats
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Data path and address width
`define PROC_XLEN 32

// Architectural register file size
`define PROC_NREGS 32

// Register index width, log2 of PROC_NREGS
`define PROC_REG_W 5

// Program counter value after reset
`define PROC_RESET_PC 32'h0000_0000

`endif

// File: hw/proc_dpath_alu.sv
// Combinational only; shifts use the low 5 bits of in1 and undefined function codes give zero
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_dpath_alu import proc_pkg::*; (
        input  logic [`PROC_XLEN-1:0] in0,
        input  logic [`PROC_XLEN-1:0] in1,
        input  alu_fn_e               fn,
        output logic [`PROC_XLEN-1:0] out,
        output logic                  ops_eq,
        output logic                  ops_lt,
        output logic                  ops_ltu
);

        logic [4:0]            shamt;
        logic [`PROC_XLEN-1:0] sum;

        assign shamt = in1[4:0];
        assign sum   = in0 + in1;                          // Shared by ADD and PC_ADD

        always_comb begin
                case (fn)
                        ALU_ADD:    out = sum;
                        ALU_SUB:    out = in0 - in1;
                        ALU_AND:    out = in0 & in1;
                        ALU_OR:     out = in0 | in1;
                        ALU_XOR:    out = in0 ^ in1;
                        ALU_SLT:    out = {31'b0, ops_lt};
                        ALU_SLTU:   out = {31'b0, ops_ltu};
                        ALU_SRA:    out = $signed(in0) >>> shamt;   // Sign bit fills in
                        ALU_SRL:    out = in0 >> shamt;
                        ALU_SLL:    out = in0 << shamt;
                        ALU_PC_ADD: out = {sum[`PROC_XLEN-1:1], 1'b0};
                        ALU_CP_OP0: out = in0;
                        ALU_CP_OP1: out = in1;
                        default:    out = '0;
                endcase
        end

        // Flags ignore fn so branches can read them with any function
        assign ops_eq  = (in0 == in1);
        assign ops_lt  = ($signed(in0) < $signed(in1));
        assign ops_ltu = (in0 < in1);

endmodule

// File: hw/proc_imm_gen.sv
// Outputs every immediate format at once; the S immediate is not built since stores are unsupported
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_imm_gen import proc_pkg::*; (
        input  instr_u                instr,
        output logic [`PROC_XLEN-1:0] imm_i,
        output logic [`PROC_XLEN-1:0] imm_b,
        output logic [`PROC_XLEN-1:0] imm_u,
        output logic [`PROC_XLEN-1:0] imm_j
);

        // 12-bit signed, for OP_IMM and JALR
        assign imm_i = {{(`PROC_XLEN-12){instr.i.imm11_0[11]}}, instr.i.imm11_0};

        // 13-bit signed branch offset, always even
        assign imm_b = {{(`PROC_XLEN-13){instr.b.imm12}},
                        instr.b.imm12,
                        instr.b.imm11,
                        instr.b.imm10_5,
                        instr.b.imm4_1,
                        1'b0};

        // Upper 20 bits, low 12 zero
        assign imm_u = {instr.u.imm31_12, 12'b0};

        // 21-bit signed jump offset, always even
        assign imm_j = {{(`PROC_XLEN-21){instr.j.imm20}},
                        instr.j.imm20,
                        instr.j.imm19_12,
                        instr.j.imm11,
                        instr.j.imm10_1,
                        1'b0};

endmodule

// File: hw/proc_pkg.sv
// Covers only the RV32I opcodes executed by this core; load, store and system formats are absent
package proc_pkg;

        // ALU function codes, codes 13 to 15 give a zero result
        typedef enum logic [3:0] {
                ALU_ADD    = 4'd0,
                ALU_SUB    = 4'd1,
                ALU_AND    = 4'd2,
                ALU_OR     = 4'd3,
                ALU_XOR    = 4'd4,
                ALU_SLT    = 4'd5,
                ALU_SLTU   = 4'd6,
                ALU_SRA    = 4'd7,
                ALU_SRL    = 4'd8,
                ALU_SLL    = 4'd9,
                ALU_PC_ADD = 4'd10,                        // Sum with bit 0 cleared
                ALU_CP_OP0 = 4'd11,
                ALU_CP_OP1 = 4'd12
        } alu_fn_e;

        // Major opcodes handled by the core
        typedef enum logic [6:0] {
                OPC_OP     = 7'b0110011,
                OPC_OP_IMM = 7'b0010011,
                OPC_LUI    = 7'b0110111,
                OPC_AUIPC  = 7'b0010111,
                OPC_JAL    = 7'b1101111,
                OPC_JALR   = 7'b1100111,
                OPC_BRANCH = 7'b1100011
        } opcode_e;

        // One instruction word seen through each base format
        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        opcode_e    opcode;
                } r;
                struct packed {
                        logic [11:0] imm11_0;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        opcode_e     opcode;
                } i;
                struct packed {
                        logic [6:0] imm11_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] imm4_0;
                        opcode_e    opcode;
                } s;
                struct packed {
                        logic       imm12;
                        logic [5:0] imm10_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [3:0] imm4_1;
                        logic       imm11;
                        opcode_e    opcode;
                } b;
                struct packed {
                        logic [19:0] imm31_12;
                        logic [4:0]  rd;
                        opcode_e     opcode;
                } u;
                struct packed {
                        logic       imm20;
                        logic [9:0] imm10_1;
                        logic       imm11;
                        logic [7:0] imm19_12;
                        logic [4:0] rd;
                        opcode_e    opcode;
                } j;
        } instr_u;

endpackage

// File: hw/proc_regfile.sv
// Register 0 reads as zero and ignores writes; a read of the register being written returns the old value
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_regfile (
        input  logic                   clk,
        input  logic                   rst_n,
        input  logic [`PROC_REG_W-1:0] raddr0,
        input  logic [`PROC_REG_W-1:0] raddr1,
        output logic [`PROC_XLEN-1:0]  rdata0,
        output logic [`PROC_XLEN-1:0]  rdata1,
        input  logic                   wen,
        input  logic [`PROC_REG_W-1:0] waddr,
        input  logic [`PROC_XLEN-1:0]  wdata
);

        logic [`PROC_XLEN-1:0] regs [1:`PROC_NREGS-1];     // No storage for x0

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        for (int k = 1; k < `PROC_NREGS; k++) begin
                                regs[k] <= '0;
                        end
                end else if (wen && waddr != '0) begin
                        regs[waddr] <= wdata;
                end
        end

        // Reads bypass the array for index 0
        assign rdata0 = (raddr0 == '0) ? '0 : regs[raddr0];
        assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];

endmodule

// File: proc_core.f
+incdir+hw
hw/proc_pkg.sv
hw/proc_dpath_alu.sv
hw/proc_regfile.sv
hw/proc_imm_gen.sv
hw/proc_ctrl.sv
hw/proc_core.sv
tb/proc_core_tb.sv

// File: tb/proc_core_tb.sv
// Random RV32I stream against an ISA model; no loads or stores, and pc may leave 4-byte alignment
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_core_tb import proc_pkg::*; ();

        localparam int NUM_INSTR  = 2000;
        localparam int MAX_CYCLES = NUM_INSTR * 3 / 2;     // About 2500 needed at 80% valid

        typedef struct packed {
                logic [`PROC_XLEN-1:0]  pc;
                logic                   wb_en;
                logic [`PROC_REG_W-1:0] rd;
                logic [`PROC_XLEN-1:0]  data;
        } commit_t;

        logic                   clk;
        logic                   rst_n;
        logic                   instr_valid;
        logic [31:0]            instr;
        logic [`PROC_XLEN-1:0]  pc;
        logic                   commit_valid;
        logic [`PROC_XLEN-1:0]  commit_pc;
        logic                   commit_wb_en;
        logic [`PROC_REG_W-1:0] commit_rd;
        logic [`PROC_XLEN-1:0]  commit_wb_data;

        logic [`PROC_XLEN-1:0]  model_regs [`PROC_NREGS];  // Entry 0 stays zero
        logic [`PROC_XLEN-1:0]  model_pc;
        commit_t                exp_q [$];                 // Commits due at the next falling edge
        int                     error_count = 0;
        int                     check_count = 0;
        int                     cycle_count = 0;
        int                     issued = 0;

        proc_core dut0 (
                .clk            (clk),
                .rst_n          (rst_n),
                .instr_valid    (instr_valid),
                .instr          (instr),
                .pc             (pc),
                .commit_valid   (commit_valid),
                .commit_pc      (commit_pc),
                .commit_wb_en   (commit_wb_en),
                .commit_rd      (commit_rd),
                .commit_wb_data (commit_wb_data)
        );

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_count <= cycle_count + 1;
                if (cycle_count >= MAX_CYCLES) begin
                        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
                        $display("Errors: %0d of %0d checks failed", error_count, check_count);
                        $display("Test failed");
                        $finish;
                end
        end

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                check_count++;
                assert (got === exp) else begin
                        error_count++;
                        $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
                end
        endtask

        // RV32I OP and OP-IMM result with alt taken from funct7 bit 5
        function automatic logic [31:0] arith_result(input logic [2:0] f3, input logic alt,
                                                     input logic [31:0] a, input logic [31:0] b);
                case (f3)
                        3'b000:  return alt ? a - b : a + b;
                        3'b001:  return a << b[4:0];
                        3'b010:  return {31'b0, $signed(a) < $signed(b)};
                        3'b011:  return {31'b0, a < b};
                        3'b100:  return a ^ b;
                        3'b101: begin
                                if (alt)
                                        return $signed(a) >>> b[4:0];
                                return a >> b[4:0];
                        end
                        3'b110:  return a | b;
                        default: return a & b;
                endcase
        endfunction

        function automatic logic [31:0] gen_instr();
                logic [31:0] word;
                logic [4:0]  rd;
                logic [4:0]  rs1;
                logic [4:0]  rs2;
                logic [2:0]  f3;
                logic [6:0]  f7;
                logic [6:0]  opc;
                logic [11:0] imm;
                int unsigned pick;
                int unsigned idx;
                logic [31:0] result;

                word = $urandom();
                rd   = 5'($urandom_range(0, 31));
                rs1  = 5'($urandom_range(0, 31));
                rs2  = 5'($urandom_range(0, 31));
                f3   = 3'($urandom_range(0, 7));
                pick = $urandom_range(0, 99);
                if (pick < 5) begin
                        do begin
                                opc = 7'($urandom_range(0, 127));
                        end while (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_AUIPC,
                                               OPC_JAL, OPC_JALR, OPC_BRANCH});
                        return {word[31:7], opc};
                end
                case (pick % 7)
                        0: begin
                                f7 = (word[0] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00;
                                result = {f7, rs2, rs1, f3, rd, OPC_OP};
                        end
                        1: begin
                                imm = word[31:20];
                                if (f3 == 3'b001)
                                        imm = {7'h00, word[24:20]};
                                else if (f3 == 3'b101)
                                        imm = {(word[0] ? 7'h20 : 7'h00), word[24:20]};
                                result = {imm, rs1, f3, rd, OPC_OP_IMM};
                        end
                        2:       result = {word[31:12], rd, OPC_LUI};
                        3:       result = {word[31:12], rd, OPC_AUIPC};
                        4:       result = {word[31:12], rd, OPC_JAL};
                        5:       result = {word[31:20], rs1, 3'b000, rd, OPC_JALR};
                        default: begin
                                idx = $urandom_range(0, 5);
                                f3  = (idx < 2) ? 3'(idx) : 3'(idx + 2);   // Skip reserved 2, 3
                                if (word[1:0] == 2'b00)
                                        rs2 = rs1;                 // Force some equal operands
                                result = {word[31:25], rs2, rs1, f3, word[11:7], OPC_BRANCH};
                        end
                endcase
                return result;
        endfunction

        task automatic model_step(input logic [31:0] iw);
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] imm_i;
                logic [31:0] imm_b;
                logic [31:0] imm_j;
                logic [31:0] next_pc;
                logic        taken;
                commit_t     c;

                a     = model_regs[iw[19:15]];
                b     = model_regs[iw[24:20]];
                imm_i = {{20{iw[31]}}, iw[31:20]};
                imm_b = {{19{iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
                imm_j = {{11{iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
                next_pc = model_pc + 32'd4;
                c.pc    = model_pc;
                c.rd    = iw[11:7];
                c.wb_en = 1'b1;
                c.data  = '0;
                case (iw[6:0])
                        OPC_OP:     c.data = arith_result(iw[14:12], iw[30], a, b);
                        OPC_OP_IMM: c.data = arith_result(iw[14:12],
                                                          iw[30] && iw[14:12] == 3'b101, a, imm_i);
                        OPC_LUI:    c.data = {iw[31:12], 12'b0};
                        OPC_AUIPC:  c.data = model_pc + {iw[31:12], 12'b0};
                        OPC_JAL: begin
                                c.data  = model_pc + 32'd4;
                                next_pc = model_pc + imm_j;
                        end
                        OPC_JALR: begin
                                c.data  = model_pc + 32'd4;
                                next_pc = (a + imm_i) & ~32'd1;
                        end
                        OPC_BRANCH: begin
                                case (iw[14:12])
                                        3'b000:  taken = (a == b);
                                        3'b001:  taken = (a != b);
                                        3'b100:  taken = ($signed(a) < $signed(b));
                                        3'b101:  taken = ($signed(a) >= $signed(b));
                                        3'b110:  taken = (a < b);
                                        3'b111:  taken = (a >= b);
                                        default: taken = 1'b0;
                                endcase
                                if (taken)
                                        next_pc = model_pc + imm_b;
                                c.wb_en = 1'b0;
                        end
                        default:    c.wb_en = 1'b0;                  // Illegal opcode retires as no-op
                endcase
                if (c.wb_en && c.rd != 5'd0)
                        model_regs[c.rd] = c.data;
                model_pc = next_pc;
                exp_q.push_back(c);
        endtask

        task automatic check_outputs();
                commit_t c;

                if (exp_q.size() > 0) begin
                        c = exp_q.pop_front();
                        check_value("commit_valid", 32'(commit_valid), 32'd1);
                        check_value("commit_pc", commit_pc, c.pc);
                        check_value("commit_wb_en", 32'(commit_wb_en), 32'(c.wb_en));
                        if (c.wb_en) begin
                                check_value("commit_rd", 32'(commit_rd), 32'(c.rd));
                                check_value("commit_wb_data", commit_wb_data, c.data);
                        end
                end else begin
                        check_value("commit_valid", 32'(commit_valid), 32'd0);
                end
                check_value("pc", pc, model_pc);                     // Idle cycles keep pc
        endtask

        task automatic drive_next();
                logic [31:0] iw;

                iw          = gen_instr();
                instr       = iw;
                instr_valid = ($urandom_range(0, 99) < 80);
                if (instr_valid) begin
                        model_step(iw);
                        issued++;
                end
        endtask

        initial begin
                void'($urandom(76));
                rst_n       = 1'b0;
                instr_valid = 1'b0;
                instr       = '0;
                model_pc    = `PROC_RESET_PC;
                for (int k = 0; k < `PROC_NREGS; k++) begin
                        model_regs[k] = '0;
                end
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                check_value("pc", pc, `PROC_RESET_PC);
                check_value("commit_valid", 32'(commit_valid), 32'd0);
                check_value("commit_wb_en", 32'(commit_wb_en), 32'd0);
                while (issued < NUM_INSTR) begin
                        drive_next();
                        @(negedge clk);
                        check_outputs();
                end
                instr_valid = 1'b0;
                @(negedge clk);
                check_outputs();
                $display("Errors: %0d of %0d checks failed", error_count, check_count);
                if (error_count == 0) begin
                        $display("Test completed successfully");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule
